/* rtl/xt_chipset_pkg.sv */
`default_nettype none

package xt_chipset_pkg;

	localparam int ADDR_W = 20;
	localparam int PHYS_W = 21;

	localparam logic [15:0] LPT_PORT = 16'h0378;
	localparam logic [15:0] XTCTL_PORT = 16'h8888;
	// decoded on address bits 15:3
	localparam logic [15:0] NMI_MASK_BASE = 16'h00A0;

	localparam logic [7:0] EMS_DISABLE_CODE = 8'hFF;
	localparam logic [7:0] EMS_MAP_LIMIT = 8'h80;
	localparam logic [7:0] NMI_MASK_RESET = 8'hFF;

	// ems frame segments, address bits 19:16
	localparam logic [3:0] FRAME_A = 4'hA;
	localparam logic [3:0] FRAME_C = 4'hC;
	localparam logic [3:0] FRAME_D = 4'hD;

	// one bus cycle, strobes active low
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0] wdata;
		logic ior_n;
		logic iow_n;
		logic memr_n;
		logic memw_n;
		logic aen_n;
	} cpu_bus_t;

	typedef struct packed {
		logic ems;
		logic lpt;
		logic xtctl;
		logic nmi_mask;
	} io_sel_t;

	// external chip selects, active low
	typedef struct packed {
		logic dma;
		logic pic;
		logic pit;
		logic ppi;
		logic dma_page;
	} periph_cs_t;

	typedef enum logic [2:0] {
		RD_NONE,
		RD_EMS,
		RD_LPT,
		RD_XTCTL,
		RD_NMI_MASK
	} rd_src_e;

	typedef enum logic [1:0] {
		EMS_DISABLE,
		EMS_MAP,
		EMS_KEEP
	} ems_action_e;

	typedef logic [5:0] ems_page_t;

endpackage

`default_nettype wire

/* rtl/io_decoder.sv */
`default_nettype none

module io_decoder import xt_chipset_pkg::*; #(
	parameter logic [15:0] ems_io_base = 16'h0260
) (
	input wire cpu_bus_t bus_i,
	input wire tandy_mode_i,
	input wire ems_enable_i,
	output io_sel_t io_sel_o,
	output periph_cs_t periph_cs_o
);

	logic io_cycle;
	logic low_page;
	logic [15:0] io_addr;

	assign io_addr = bus_i.addr[15:0];
	assign io_cycle = ~bus_i.aen_n & (~bus_i.ior_n | ~bus_i.iow_n);
	// motherboard devices live below 0x100
	assign low_page = io_cycle & (io_addr[15:8] == 8'h00);

	always_comb begin
		periph_cs_o = '1;
		if (low_page) begin
			case (io_addr[7:5])
				3'd0: periph_cs_o.dma = 1'b0;
				3'd1: periph_cs_o.pic = 1'b0;
				3'd2: periph_cs_o.pit = 1'b0;
				3'd3: periph_cs_o.ppi = 1'b0;
				3'd4: periph_cs_o.dma_page = 1'b0;
				default: periph_cs_o = '1;
			endcase
		end
	end

	always_comb begin
		io_sel_o = '0;
		if (io_cycle) begin
			io_sel_o.lpt = (io_addr == LPT_PORT);
			io_sel_o.xtctl = (io_addr == XTCTL_PORT);
			// eight ports from 0xA0, tandy only
			io_sel_o.nmi_mask = tandy_mode_i &
				(io_addr[15:3] == NMI_MASK_BASE[15:3]);
			// four page registers
			io_sel_o.ems = ems_enable_i &
				(io_addr[15:2] == ems_io_base[15:2]);
		end
	end

endmodule

`default_nettype wire

/* rtl/ems_mapper.sv */
`default_nettype none

module ems_mapper import xt_chipset_pkg::*; (
	input wire clock,
	input wire reset,
	input wire cpu_bus_t bus_i,
	input wire ems_sel_i,
	input wire [1:0] ems_frame_i,
	output logic [PHYS_W-1:0] phys_addr_o,
	output logic [7:0] rd_data_o
);

	ems_page_t page_num [4];
	logic [3:0] page_en;

	logic wr_pend;
	ems_action_e wr_action;
	ems_action_e wr_action_d;
	logic [1:0] wr_idx;
	ems_page_t wr_page;

	logic mem_cycle;
	logic [3:0] frame_code;
	logic [1:0] frame_page;
	logic [1:0] rd_idx;

	always_comb begin
		if (bus_i.wdata == EMS_DISABLE_CODE)
			wr_action_d = EMS_DISABLE;
		else if (bus_i.wdata < EMS_MAP_LIMIT)
			wr_action_d = EMS_MAP;
		else
			wr_action_d = EMS_KEEP;
	end

	// first stage, capture the write
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wr_pend <= 1'b0;
			wr_action <= EMS_KEEP;
		end else begin
			wr_pend <= ems_sel_i & ~bus_i.iow_n;
			wr_action <= wr_action_d;
		end
	end

	always_ff @(posedge clock) begin
		wr_idx <= bus_i.addr[1:0];
		wr_page <= bus_i.wdata[5:0];
	end

	// second stage, update the page
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			page_en <= '0;
			for (int i = 0; i < 4; i++)
				page_num[i] <= '0;
		end else if (wr_pend) begin
			case (wr_action)
				EMS_DISABLE: page_en[wr_idx] <= 1'b0;
				EMS_MAP: begin
					page_en[wr_idx] <= 1'b1;
					page_num[wr_idx] <= wr_page;
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		case (ems_frame_i)
			2'd0: frame_code = FRAME_A;
			2'd1: frame_code = FRAME_C;
			default: frame_code = FRAME_D;
		endcase
	end

	assign mem_cycle = ~bus_i.aen_n & bus_i.ior_n & bus_i.iow_n &
		(~bus_i.memr_n | ~bus_i.memw_n);
	assign frame_page = bus_i.addr[15:14];

	always_comb begin
		if (mem_cycle && bus_i.addr[19:16] == frame_code && page_en[frame_page])
			phys_addr_o = {1'b1, page_num[frame_page], bus_i.addr[13:0]};
		else
			phys_addr_o = {1'b0, bus_i.addr};
	end

	assign rd_idx = bus_i.addr[1:0];
	assign rd_data_o = page_en[rd_idx] ? {2'b00, page_num[rd_idx]} : EMS_DISABLE_CODE;

endmodule

`default_nettype wire

/* rtl/port_registers.sv */
`default_nettype none

module port_registers import xt_chipset_pkg::*; (
	input wire clock,
	input wire reset,
	input wire cpu_bus_t bus_i,
	input wire io_sel_t io_sel_i,
	output logic [7:0] lpt_o,
	output logic [7:0] xtctl_o,
	output logic [7:0] nmi_mask_o
);

	logic write_cycle;

	assign write_cycle = ~bus_i.iow_n;

	// printer data latch
	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			lpt_o <= 8'h00;
		else if (io_sel_i.lpt && write_cycle)
			lpt_o <= bus_i.wdata;
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			xtctl_o <= 8'h00;
		else if (io_sel_i.xtctl && write_cycle)
			xtctl_o <= bus_i.wdata;
	end

	// nmi masked out of reset
	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			nmi_mask_o <= NMI_MASK_RESET;
		else if (io_sel_i.nmi_mask && write_cycle)
			nmi_mask_o <= bus_i.wdata;
	end

endmodule

`default_nettype wire

/* rtl/bus_read_mux.sv */
`default_nettype none

module bus_read_mux import xt_chipset_pkg::*; (
	input wire clock,
	input wire reset,
	input wire cpu_bus_t bus_i,
	input wire io_sel_t io_sel_i,
	input wire [7:0] ems_data_i,
	input wire [7:0] lpt_i,
	input wire [7:0] xtctl_i,
	input wire [7:0] nmi_mask_i,
	output logic [7:0] data_o,
	output logic data_valid_o
);

	rd_src_e rd_src;

	// ems wins over the small ports
	always_comb begin
		rd_src = RD_NONE;
		if (~bus_i.ior_n) begin
			if (io_sel_i.ems)
				rd_src = RD_EMS;
			else if (io_sel_i.nmi_mask)
				rd_src = RD_NMI_MASK;
			else if (io_sel_i.lpt)
				rd_src = RD_LPT;
			else if (io_sel_i.xtctl)
				rd_src = RD_XTCTL;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			data_o <= 8'h00;
			data_valid_o <= 1'b0;
		end else begin
			data_valid_o <= (rd_src != RD_NONE);
			case (rd_src)
				RD_EMS: data_o <= ems_data_i;
				RD_NMI_MASK: data_o <= nmi_mask_i;
				RD_LPT: data_o <= lpt_i;
				RD_XTCTL: data_o <= xtctl_i;
				default: data_o <= 8'h00;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/xt_chipset_top.sv */
`default_nettype none

module xt_chipset_top import xt_chipset_pkg::*; #(
	parameter logic [15:0] ems_io_base = 16'h0260
) (
	input wire clock,
	input wire reset,
	input wire cpu_bus_t bus_i,
	input wire ems_enable_i,
	input wire [1:0] ems_frame_i,
	input wire tandy_mode_i,
	output periph_cs_t periph_cs_o,
	output logic [PHYS_W-1:0] phys_addr_o,
	output logic [7:0] lpt_o,
	output logic [7:0] xtctl_o,
	output logic [7:0] data_o,
	output logic data_valid_o
);

	io_sel_t io_sel;
	logic [7:0] ems_rd_data;
	logic [7:0] nmi_mask;

	io_decoder #(
		.ems_io_base(ems_io_base)
	) io_decoder0 (
		.bus_i(bus_i),
		.tandy_mode_i(tandy_mode_i),
		.ems_enable_i(ems_enable_i),
		.io_sel_o(io_sel),
		.periph_cs_o(periph_cs_o)
	);

	ems_mapper ems_mapper0 (
		.clock(clock),
		.reset(reset),
		.bus_i(bus_i),
		.ems_sel_i(io_sel.ems),
		.ems_frame_i(ems_frame_i),
		.phys_addr_o(phys_addr_o),
		.rd_data_o(ems_rd_data)
	);

	port_registers port_registers0 (
		.clock(clock),
		.reset(reset),
		.bus_i(bus_i),
		.io_sel_i(io_sel),
		.lpt_o(lpt_o),
		.xtctl_o(xtctl_o),
		.nmi_mask_o(nmi_mask)
	);

	// read-back path, one clock behind the strobe
	bus_read_mux bus_read_mux0 (
		.clock(clock),
		.reset(reset),
		.bus_i(bus_i),
		.io_sel_i(io_sel),
		.ems_data_i(ems_rd_data),
		.lpt_i(lpt_o),
		.xtctl_i(xtctl_o),
		.nmi_mask_i(nmi_mask),
		.data_o(data_o),
		.data_valid_o(data_valid_o)
	);

endmodule

`default_nettype wire

/* tests/tb_xt_chipset.sv */
`default_nettype none

module tb_xt_chipset import xt_chipset_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// the tests take about 520 cycles
	localparam int MAX_CYCLES = 4000;
	localparam logic [15:0] EMS_BASE = 16'h0260;

	logic clock = 1'b0;
	logic reset;
	cpu_bus_t bus;
	logic ems_enable;
	logic [1:0] ems_frame;
	logic tandy_mode;
	periph_cs_t periph_cs;
	logic [PHYS_W-1:0] phys_addr;
	logic [7:0] lpt;
	logic [7:0] xtctl;
	logic [7:0] data;
	logic data_valid;

	logic [31:0] lfsr = 32'h4fa2_fee3;
	int errors = 0;
	int tests = 0;
	int failed_tests = 0;
	int test_errors = 0;
	int cycles = 0;
	logic exp_en [4];
	logic [5:0] exp_num [4];

	xt_chipset_top #(
		.ems_io_base(EMS_BASE)
	) dut0 (
		.clock(clock),
		.reset(reset),
		.bus_i(bus),
		.ems_enable_i(ems_enable),
		.ems_frame_i(ems_frame),
		.tandy_mode_i(tandy_mode),
		.periph_cs_o(periph_cs),
		.phys_addr_o(phys_addr),
		.lpt_o(lpt),
		.xtctl_o(xtctl),
		.data_o(data),
		.data_valid_o(data_valid)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// at most one external device selected
	assert property (@(posedge clock) disable iff (reset) $countones(~periph_cs) <= 1)
	else begin
		$display("more than one chip select low at %0t", $time);
		errors++;
	end

	// taps 32 22 2 1
	function automatic logic [7:0] rand_byte();
		logic [7:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < 8; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[6:0], fb};
		end
		return r;
	endfunction

	function automatic void ems_model(input int idx, input logic [7:0] wdata);
		if (wdata == 8'hFF) begin
			exp_en[idx] = 1'b0;
		end else if (wdata < 8'h80) begin
			exp_en[idx] = 1'b1;
			exp_num[idx] = wdata[5:0];
		end
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("error t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == test_errors) begin
			$display("test %s passed", name);
		end else begin
			failed_tests++;
			$display("test %s failed with %0d errors", name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	task automatic bus_idle();
		bus.ior_n = 1'b1;
		bus.iow_n = 1'b1;
		bus.memr_n = 1'b1;
		bus.memw_n = 1'b1;
		bus.aen_n = 1'b0;
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] wdata);
		@(negedge clock);
		bus.addr = {4'h0, addr};
		bus.wdata = wdata;
		bus.iow_n = 1'b0;
		@(negedge clock);
		bus_idle();
	endtask

	// data is registered on the edge under the strobe
	task automatic io_read(input logic [15:0] addr, output logic [7:0] rdata,
		output logic valid);
		@(negedge clock);
		bus.addr = {4'h0, addr};
		bus.ior_n = 1'b0;
		@(negedge clock);
		bus_idle();
		rdata = data;
		valid = data_valid;
	endtask

	task automatic mem_access(input logic [19:0] addr, input logic write,
		output logic [PHYS_W-1:0] phys);
		@(negedge clock);
		bus.addr = addr;
		bus.memr_n = write;
		bus.memw_n = ~write;
		#2;
		phys = phys_addr;
		@(negedge clock);
		bus_idle();
	endtask

	task automatic sample_cs(input logic [19:0] addr, input logic io, input logic aen_n,
		output periph_cs_t cs);
		@(negedge clock);
		bus.addr = addr;
		bus.aen_n = aen_n;
		if (io)
			bus.ior_n = 1'b0;
		else
			bus.memr_n = 1'b0;
		#2;
		cs = periph_cs;
		@(negedge clock);
		bus_idle();
	endtask

	initial begin
		periph_cs_t cs;
		periph_cs_t exp_cs;
		logic [7:0] value;
		logic [7:0] sub;
		logic [7:0] rd_data;
		logic rd_valid;
		logic [15:0] offset;
		logic [19:0] addr;
		logic [3:0] code;
		logic [PHYS_W-1:0] phys;
		logic [PHYS_W-1:0] exp_phys;

		reset = 1'b1;
		bus = '0;
		bus_idle();
		ems_enable = 1'b0;
		ems_frame = 2'd0;
		tandy_mode = 1'b0;
		for (int i = 0; i < 4; i++) begin
			exp_en[i] = 1'b0;
			exp_num[i] = 6'd0;
		end
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		check("data_valid_o", data_valid, 1'b0);
		check("periph_cs_o", periph_cs, 5'h1f);
		check("lpt_o", lpt, 8'h00);
		check("xtctl_o", xtctl, 8'h00);
		tandy_mode = 1'b1;
		sub = rand_byte();
		io_read({13'h0014, sub[2:0]}, rd_data, rd_valid);
		check("data_valid_o", rd_valid, 1'b1);
		check("data_o", rd_data, 8'hFF);
		report_test("reset state");

		tandy_mode = 1'b0;
		for (int i = 0; i < 40; i++) begin
			value = rand_byte();
			exp_cs = '1;
			case (value[7:5])
				3'd0: exp_cs.dma = 1'b0;
				3'd1: exp_cs.pic = 1'b0;
				3'd2: exp_cs.pit = 1'b0;
				3'd3: exp_cs.ppi = 1'b0;
				3'd4: exp_cs.dma_page = 1'b0;
				default: ;
			endcase
			sample_cs({12'h000, value}, 1'b1, 1'b0, cs);
			check("periph_cs_o", cs, exp_cs);
			sample_cs({12'h000, value}, 1'b0, 1'b0, cs);
			check("periph_cs_o", cs, 5'h1f);
			sample_cs({12'h000, value}, 1'b1, 1'b1, cs);
			check("periph_cs_o", cs, 5'h1f);
		end
		report_test("external decode");

		for (int i = 0; i < 8; i++) begin
			value = rand_byte();
			io_write(16'h0378, value);
			check("lpt_o", lpt, value);
			io_read(16'h0378, rd_data, rd_valid);
			check("data_valid_o", rd_valid, 1'b1);
			check("data_o", rd_data, value);
			value = rand_byte();
			io_write(16'h8888, value);
			check("xtctl_o", xtctl, value);
			io_read(16'h8888, rd_data, rd_valid);
			check("data_valid_o", rd_valid, 1'b1);
			check("data_o", rd_data, value);
			// nmi mask port, any of the eight
			tandy_mode = 1'b1;
			value = rand_byte();
			sub = rand_byte();
			io_write({13'h0014, sub[2:0]}, value);
			io_read({13'h0014, sub[5:3]}, rd_data, rd_valid);
			check("data_valid_o", rd_valid, 1'b1);
			check("data_o", rd_data, value);
			tandy_mode = 1'b0;
			io_read({13'h0014, sub[2:0]}, rd_data, rd_valid);
			check("data_valid_o", rd_valid, 1'b0);
			check("data_o", rd_data, 8'h00);
		end
		report_test("register read-back");

		ems_enable = 1'b1;
		for (int p = 0; p < 4; p++) begin
			for (int k = 0; k < 5; k++) begin
				value = rand_byte();
				case (k)
					0, 2: value = 8'h80 + (value % 8'h7F);
					1, 4: value = {1'b0, value[6:0]};
					default: value = 8'hFF;
				endcase
				io_write({EMS_BASE[15:2], p[1:0]}, value);
				ems_model(p, value);
				io_read({EMS_BASE[15:2], p[1:0]}, rd_data, rd_valid);
				check("data_valid_o", rd_valid, 1'b1);
				check("data_o", rd_data, exp_en[p] ? {2'b00, exp_num[p]} : 8'hFF);
			end
		end
		ems_enable = 1'b0;
		io_read(EMS_BASE, rd_data, rd_valid);
		check("data_valid_o", rd_valid, 1'b0);
		check("data_o", rd_data, 8'h00);
		report_test("ems write rules");

		// page 2 off so the frame holds both cases
		ems_enable = 1'b1;
		io_write({EMS_BASE[15:2], 2'd2}, 8'hFF);
		ems_model(2, 8'hFF);
		for (int f = 0; f < 4; f++) begin
			ems_frame = f[1:0];
			code = (f == 0) ? 4'hA : (f == 1) ? 4'hC : 4'hD;
			for (int p = 0; p < 4; p++) begin
				offset = {rand_byte(), rand_byte()};
				addr = {code, p[1:0], offset[13:0]};
				if (exp_en[p])
					exp_phys = {1'b1, exp_num[p], offset[13:0]};
				else
					exp_phys = {1'b0, addr};
				mem_access(addr, p[0], phys);
				check("phys_addr_o", phys, exp_phys);
				addr[19:16] = code ^ 4'h3;
				mem_access(addr, p[1], phys);
				check("phys_addr_o", phys, {1'b0, addr});
			end
		end
		report_test("ems translation");

		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
rtl/xt_chipset_pkg.sv
rtl/io_decoder.sv
rtl/ems_mapper.sv
rtl/port_registers.sv
rtl/bus_read_mux.sv
rtl/xt_chipset_top.sv
tests/tb_xt_chipset.sv

/* Bender.yml */
package:
  name: xt_chipset

sources:
  - rtl/xt_chipset_pkg.sv
  - rtl/io_decoder.sv
  - rtl/ems_mapper.sv
  - rtl/port_registers.sv
  - rtl/bus_read_mux.sv
  - rtl/xt_chipset_top.sv
  - target: test
    files:
      - tests/tb_xt_chipset.sv
